//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= stage1Ctrl_tb
RTL_TOP   ?= stage1Ctrl
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f compile.f --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f compile.f --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/decodeIf.sv
verilog/instrDecode.sv
verilog/cacheWait.sv
verilog/opSequencer.sv
verilog/ctrlEncoder.sv
verilog/stage1Ctrl.sv
dv/stage1Ctrl_tb.sv

//--- dv/stage1Ctrl_tb.sv
`timescale 1ns/1ns
`include "stage1_defs.svh"

module stage1Ctrl_tb import isaPkg::*, ctrlPkg::*; ();

	typedef struct packed {
		int          marLoads;
		int          memReads;
		int          accWrites;
		int          memWrites;
		int          shiftEns;
		int          lowCycles;
		logic        fixedLen;    // Busy time not set by the cache
		ctrlWord_t   execWord;
		ctrlWord_t   shiftWord;
		shiftCount_t count;
	} expect_t;

	logic        clk;
	logic        reset;
	instr_t      instr;
	data_t       irData;
	logic        stage0Valid;
	logic        cacheHit;
	logic        stage1Ready;
	ctrlWord_t   ctrl;
	shiftCount_t shiftCount;

	logic [31:0] rngState = 32'he2a7_249c;
	logic        forceMiss;
	logic        collecting;
	logic        lastMemRead;
	logic        lastMemWrite;
	int          hitDelay;
	int          errors;
	int          tests;
	int          marSeen, accSeen, memRdSeen, memWrSeen, shiftEnSeen, lowSeen;
	ctrlWord_t   execSeen, shiftSeen, ctrlOr;
	opcode_t     memOps [6] = '{`OP_ADD, `OP_SUB, `OP_OR, `OP_AND, `OP_LOAD, `OP_STOR};

	stage1Ctrl i_stage1Ctrl (
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.irData      (irData),
		.stage0Valid (stage0Valid),
		.cacheHit    (cacheHit),
		.stage1Ready (stage1Ready),
		.ctrl        (ctrl),
		.shiftCount  (shiftCount)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	////////////////////
	// Cache model

	initial begin
		cacheHit = 1'b0;
		hitDelay = -1;
		forever begin
			@(posedge clk);
			#1;
			if (forceMiss) begin
				cacheHit = 1'b0;
			end else if (ctrl[`CB_MARLOAD]) begin
				rngState = lcgNext(rngState);
				cacheHit = 1'b0;
				hitDelay = int'(rngState[19:16]);   // 0 to 15 cycles
			end else if (hitDelay == 0) begin
				cacheHit = 1'b1;
				hitDelay = -1;
			end else if (hitDelay > 0) begin
				hitDelay--;
			end
		end
	end

	// Sampled mid-cycle where ctrl is settled
	always @(negedge clk) begin
		if (collecting) begin
			if (ctrl[`CB_MARLOAD]) marSeen++;
			if (ctrl[`CB_MEMREAD] && !lastMemRead) memRdSeen++;    // One burst per read state
			lastMemRead = ctrl[`CB_MEMREAD];
			if (ctrl[`CB_MEMWRITE] && !lastMemWrite) memWrSeen++;   // One burst per store
			lastMemWrite = ctrl[`CB_MEMWRITE];
			if (ctrl[`CB_ACCWRITE]) begin
				accSeen++;
				execSeen = ctrl;
			end
			if (ctrl[`CB_SHIFTEN]) begin
				shiftEnSeen++;
				shiftSeen = ctrl;
			end
			if (!stage1Ready) lowSeen++;
			ctrlOr = ctrlOr | ctrl;
		end
	end

	////////////////////
	// Expected results

	function automatic expect_t refModel(instr_t word, data_t data);
		expect_t  e;
		opcode_t  opc;
		flag_t    fl;
		aluFunc_t fn;
		logic     isMem;
		e   = '0;
		opc = word[7:3];
		fl  = word[2:0];
		case (opc)
			`OP_ADD: fn = aluAdd;
			`OP_SUB: fn = aluSub;
			`OP_OR:  fn = aluOr;
			`OP_AND: fn = aluAnd;
			default: fn = aluPass;
		endcase
		isMem = (opc inside {`OP_ADD, `OP_SUB, `OP_OR, `OP_AND, `OP_LOAD} && fl <= `FL_IMM)
			|| (opc == `OP_STOR && fl <= `FL_IND);
		e.fixedLen = 1'b1;
		if (isMem) begin
			e.marLoads  = (fl == `FL_IND) ? 2 : (fl == `FL_DIR) ? 1 : 0;
			e.memReads  = ((fl == `FL_IND) ? 1 : 0)
				+ ((opc != `OP_STOR && fl != `FL_IMM) ? 1 : 0);
			e.fixedLen  = (fl == `FL_IMM);
			e.lowCycles = 1;
			if (opc == `OP_STOR) begin
				e.memWrites = 1;
			end else begin
				e.accWrites = 1;
				e.execWord[`CB_ACCWRITE]     = 1'b1;
				e.execWord[`CB_ALUFUNC +: 3] = fn;
				e.execWord[`CB_OPSEL]        = (fl == `FL_IMM);
			end
		end else if (opc == `OP_SHFT && fl <= `FL_RS1) begin
			e.shiftEns  = 1;
			e.lowCycles = 1;
			e.shiftWord[`CB_SHIFTEN]   = 1'b1;
			e.shiftWord[`CB_SHIFTDIR]  = (fl == `FL_RS0 || fl == `FL_RS1);
			e.shiftWord[`CB_SHIFTFILL] = (fl == `FL_LS1 || fl == `FL_RS1);
			e.count = data[2:0];
		end
		return e;
	endfunction

	task automatic checkCtrl(string name, ctrlWord_t got, ctrlWord_t want);
		if (got !== want) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic checkShift(string name, shiftCount_t got, shiftCount_t want);
		if (got !== want) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic checkCount(string name, int got, int want);
		if (got != want) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	task automatic waitReady();
		int n;
		n = 0;
		while (!stage1Ready && n < 100) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!stage1Ready) begin
			$display("Timeout: stage1Ready stayed low for 100 cycles");
			errors++;
		end
	endtask

	task automatic runTest(string label, instr_t word);
		expect_t e;
		data_t   data;
		int      errBefore;
		rngState  = lcgNext(rngState);
		data      = rngState[23:16];
		e         = refModel(word, data);
		errBefore = errors;
		waitReady();
		marSeen      = 0;
		accSeen      = 0;
		memRdSeen    = 0;
		memWrSeen    = 0;
		shiftEnSeen  = 0;
		lowSeen      = 0;
		lastMemRead  = 1'b0;
		lastMemWrite = 1'b0;
		ctrlOr       = '0;
		instr        = word;
		irData       = data;
		stage0Valid  = 1'b1;
		@(posedge clk);   // Accept edge
		#1;
		stage0Valid = 1'b0;
		instr       = 8'hff;   // Decoder has to keep the captured word
		irData      = ~data;
		collecting  = 1'b1;
		@(posedge clk);
		#1;
		waitReady();
		collecting = 1'b0;
		checkCount("marLoad", marSeen, e.marLoads);
		checkCount("memRead", memRdSeen, e.memReads);
		checkCount("accWrite", accSeen, e.accWrites);
		checkCount("memWrite", memWrSeen, e.memWrites);
		checkCount("shiftEn", shiftEnSeen, e.shiftEns);
		if (e.fixedLen) checkCount("stage1Ready low", lowSeen, e.lowCycles);
		if (e.accWrites > 0) checkCtrl("ctrl exec", execSeen, e.execWord);
		if (e.shiftEns > 0) begin
			checkCtrl("ctrl shift", shiftSeen, e.shiftWord);
			checkShift("shiftCount", shiftCount, e.count);
		end
		if (e.fixedLen && e.lowCycles == 0) checkCtrl("ctrl", ctrlOr, '0);
		tests++;
		$display("test %0d %s instr 0x%h: %s", tests, label, word,
			(errors == errBefore) ? "ok" : "errors");
	endtask

	////////////////////
	// Test sequence

	initial begin
		reset       = 1'b1;
		instr       = '0;
		irData      = '0;
		stage0Valid = 1'b0;
		forceMiss   = 1'b0;
		collecting  = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		checkCount("stage1Ready", int'(stage1Ready), 1);
		checkCtrl("ctrl", ctrl, '0);
		checkShift("shiftCount", shiftCount, '0);
		tests++;
		$display("test %0d reset: %s", tests, (errors == 0) ? "ok" : "errors");
		for (int f = 0; f < 4; f++) runTest("shift", {`OP_SHFT, flag_t'(f)});
		runTest("nop", {`OP_NOP, `FL_DIR});
		runTest("unknown", {5'b11111, `FL_DIR});
		for (int m = 0; m < 2; m++) begin
			forceMiss = (m == 1);   // Second pass never hits
			for (int i = 0; i < 6; i++) begin
				for (int f = 0; f < 3; f++) begin
					runTest(forceMiss ? "miss" : "hit", {memOps[i], flag_t'(f)});
				end
			end
		end
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- verilog/cacheWait.sv
`timescale 1ns/1ns
`include "stage1_defs.svh"

module cacheWait (
	input  logic clk,
	input  logic reset,
	input  logic cacheHit,
	input  logic waitStart,
	output logic waitDone
);

	localparam int MISS_W = $clog2(`MISS_LIMIT + 1);

	logic              active;
	logic              settle;     // Hit ignored in the first wait cycle
	logic [MISS_W-1:0] missCount;

	assign waitDone = active && !settle &&
		(cacheHit || missCount == MISS_W'(`MISS_LIMIT));

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			settle    <= 1'b0;
			missCount <= '0;
		end else if (waitStart) begin
			active    <= 1'b1;
			settle    <= 1'b1;
			missCount <= '0;
		end else if (active) begin
			if (settle) begin
				settle <= 1'b0;
			end else if (waitDone) begin
				active <= 1'b0;                    // Back to idle
			end else begin
				missCount <= missCount + 1'b1;
			end
		end
	end

endmodule

//--- verilog/ctrlEncoder.sv
`timescale 1ns/1ns
`include "stage1_defs.svh"

module ctrlEncoder import isaPkg::*, ctrlPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  seqState_t   state,
	input  data_t       irData,
	decodeIf.encoder    dec,
	output ctrlWord_t   ctrl,
	output shiftCount_t shiftCount
);

	logic isStore;

	assign isStore = (dec.opClass == classStore);

	////////////////////
	// Control word

	always_comb begin
		ctrl = '0;
		case (state)
			sAddr, sPtrAddr: ctrl[`CB_MARLOAD] = 1'b1;
			sPtrWait:        ctrl[`CB_MEMREAD] = 1'b1;     // Pointer fetch
			sMemWait: begin
				ctrl[`CB_MEMWRITE] = isStore;
				ctrl[`CB_MEMREAD]  = !isStore;
			end
			sExec: begin
				ctrl[`CB_ACCWRITE]      = 1'b1;
				ctrl[`CB_ALUFUNC +: 3]  = dec.aluFunc;
				ctrl[`CB_OPSEL]         = (dec.addrMode == modeImm);
			end
			sShift: begin
				ctrl[`CB_SHIFTEN]   = 1'b1;
				ctrl[`CB_SHIFTDIR]  = dec.shiftDir;
				ctrl[`CB_SHIFTFILL] = dec.shiftFill;
			end
			default: ctrl = '0;
		endcase
	end

	// Count taken on the edge into sShift and held
	always_ff @(posedge clk) begin
		if (reset) begin
			shiftCount <= '0;
		end else if (dec.capture && dec.opClass == classShift) begin
			shiftCount <= irData[`SHIFT_W-1:0];
		end
	end

endmodule

//--- verilog/ctrlPkg.sv
`include "stage1_defs.svh"

package ctrlPkg;

	////////////////////
	// Datapath control

	typedef logic [`CTRL_W-1:0]  ctrlWord_t;
	typedef logic [`SHIFT_W-1:0] shiftCount_t;

	// Fills the 3-bit ALU field of the control word
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluOr,
		aluAnd,
		aluPass     // LOAD passes the operand through
	} aluFunc_t;

	typedef enum logic [2:0] {
		classAlu,
		classLoad,
		classStore,
		classShift,
		classNop
	} opClass_t;

	////////////////////
	// Sequencer states

	typedef enum logic [2:0] {
		sIdle,      // Ready for stage 0
		sAddr,      // MAR load of the operand address
		sPtrWait,   // Pointer read for indirect
		sPtrAddr,   // MAR load from the pointer
		sMemWait,   // Operand read or store write
		sExec,
		sShift
	} seqState_t;

	function automatic logic isMemClass(opClass_t cls);
		return (cls == classAlu) || (cls == classLoad) || (cls == classStore);
	endfunction

endpackage

//--- verilog/decodeIf.sv
`timescale 1ns/1ns

interface decodeIf import isaPkg::*, ctrlPkg::*; ();

	logic      capture;    // Accept strobe
	opClass_t  opClass;
	addrMode_t addrMode;
	aluFunc_t  aluFunc;
	logic      shiftDir;   // 1 for right
	logic      shiftFill;

	modport decoder (input capture,
		output opClass, addrMode, aluFunc, shiftDir, shiftFill);

	modport sequencer (output capture, input opClass, addrMode);

	modport encoder (input capture, opClass, addrMode, aluFunc, shiftDir, shiftFill);

endinterface

//--- verilog/instrDecode.sv
`timescale 1ns/1ns
`include "stage1_defs.svh"

module instrDecode import isaPkg::*, ctrlPkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  instr_t instr,
	decodeIf.decoder dec
);

	instr_t    instrReg;
	instr_t    curInstr;
	opcode_t   opc;
	flag_t     flags;
	addrMode_t mode;
	logic      modeValid;

	always_ff @(posedge clk) begin
		if (reset) begin
			instrReg <= {`OP_NOP, `FL_DIR};
		end else if (dec.capture) begin
			instrReg <= instr;
		end
	end

	// Bypass on the accept cycle so the FSM can branch on the new word
	assign curInstr = dec.capture ? instr : instrReg;
	assign opc      = opcodeOf(curInstr);
	assign flags    = flagsOf(curInstr);

	always_comb begin
		mode          = modeOf(flags, modeValid);
		dec.opClass   = classNop;
		dec.aluFunc   = aluPass;
		dec.addrMode  = mode;
		dec.shiftDir  = 1'b0;
		dec.shiftFill = 1'b0;
		case (opc)
			`OP_ADD:  dec.aluFunc = aluAdd;
			`OP_SUB:  dec.aluFunc = aluSub;
			`OP_OR:   dec.aluFunc = aluOr;
			`OP_AND:  dec.aluFunc = aluAnd;
			default:  dec.aluFunc = aluPass;
		endcase
		case (opc)
			`OP_ADD, `OP_SUB, `OP_OR, `OP_AND: begin
				if (modeValid) dec.opClass = classAlu;
			end
			`OP_LOAD: begin
				if (modeValid) dec.opClass = classLoad;
			end
			`OP_STOR: begin
				if (modeValid && mode != modeImm) dec.opClass = classStore;  // No immediate store
			end
			`OP_SHFT: begin
				dec.opClass = classShift;
				case (flags)
					`FL_LS0: {dec.shiftDir, dec.shiftFill} = 2'b00;
					`FL_LS1: {dec.shiftDir, dec.shiftFill} = 2'b01;
					`FL_RS0: {dec.shiftDir, dec.shiftFill} = 2'b10;
					`FL_RS1: {dec.shiftDir, dec.shiftFill} = 2'b11;
					default: dec.opClass = classNop;
				endcase
			end
			`OP_NOP:  dec.opClass = classNop;
			default:  dec.opClass = classNop;    // Dropped opcodes
		endcase
	end

endmodule

//--- verilog/isaPkg.sv
`include "stage1_defs.svh"

package isaPkg;

	////////////////////
	// Instruction side

	typedef logic [`INSTR_W-1:0] instr_t;   // Opcode in the top bits
	typedef logic [`OPC_W-1:0]   opcode_t;
	typedef logic [`FLAG_W-1:0]  flag_t;
	typedef logic [`DATA_W-1:0]  data_t;    // Stage-0 data register

	typedef enum logic [1:0] {
		modeDir,
		modeInd,
		modeImm
	} addrMode_t;

	function automatic opcode_t opcodeOf(instr_t word);
		return word[`INSTR_W-1 -: `OPC_W];
	endfunction

	function automatic flag_t flagsOf(instr_t word);
		return word[`FLAG_W-1:0];
	endfunction

	// Addressing mode of the flag field and whether the code is known
	function automatic addrMode_t modeOf(flag_t flags, output logic valid);
		addrMode_t mode;
		valid = 1'b1;
		case (flags)
			`FL_DIR: mode = modeDir;
			`FL_IND: mode = modeInd;
			`FL_IMM: mode = modeImm;
			default: begin
				mode = modeDir;
				valid = 1'b0;
			end
		endcase
		return mode;
	endfunction

endpackage

//--- verilog/opSequencer.sv
`timescale 1ns/1ns

module opSequencer import isaPkg::*, ctrlPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      stage0Valid,
	input  logic      waitDone,
	decodeIf.sequencer dec,
	output logic      waitStart,
	output seqState_t state,
	output logic      stage1Ready
);

	seqState_t nextState;

	assign stage1Ready = (state == sIdle);
	assign dec.capture = stage1Ready && stage0Valid;

	// One cycle before each wait state
	assign waitStart = (state == sAddr) || (state == sPtrAddr);

	////////////////////
	// State register

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sIdle;
		end else begin
			state <= nextState;
		end
	end

	////////////////////
	// Next state

	always_comb begin
		nextState = state;
		case (state)
			sIdle: begin
				if (dec.capture) begin
					if (dec.opClass == classShift) begin
						nextState = sShift;
					end else if (isMemClass(dec.opClass)) begin
						if (dec.addrMode == modeImm) begin
							nextState = sExec;    // Operand is in the data register
						end else begin
							nextState = sAddr;
						end
					end
				end
			end
			sAddr: begin
				if (dec.addrMode == modeInd) begin
					nextState = sPtrWait;
				end else begin
					nextState = sMemWait;
				end
			end
			sPtrWait: begin
				if (waitDone) nextState = sPtrAddr;
			end
			sPtrAddr: nextState = sMemWait;
			sMemWait: begin
				if (waitDone) begin
					if (dec.opClass == classStore) begin
						nextState = sIdle;      // Store is done once written
					end else begin
						nextState = sExec;
					end
				end
			end
			sExec:    nextState = sIdle;
			sShift:   nextState = sIdle;
			default:  nextState = sIdle;
		endcase
	end

endmodule

//--- verilog/stage1Ctrl.sv
`timescale 1ns/1ns

module stage1Ctrl import isaPkg::*, ctrlPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  instr_t      instr,
	input  data_t       irData,
	input  logic        stage0Valid,
	input  logic        cacheHit,
	output logic        stage1Ready,
	output ctrlWord_t   ctrl,
	output shiftCount_t shiftCount
);

	logic      waitStart;
	logic      waitDone;
	seqState_t state;

	decodeIf dec ();

	instrDecode i_instrDecode (
		.clk   (clk),
		.reset (reset),
		.instr (instr),
		.dec   (dec.decoder)
	);

	cacheWait i_cacheWait (
		.clk       (clk),
		.reset     (reset),
		.cacheHit  (cacheHit),
		.waitStart (waitStart),
		.waitDone  (waitDone)
	);

	opSequencer i_opSequencer (
		.clk         (clk),
		.reset       (reset),
		.stage0Valid (stage0Valid),
		.waitDone    (waitDone),
		.dec         (dec.sequencer),
		.waitStart   (waitStart),
		.state       (state),
		.stage1Ready (stage1Ready)
	);

	ctrlEncoder i_ctrlEncoder (
		.clk        (clk),
		.reset      (reset),
		.state      (state),
		.irData     (irData),
		.dec        (dec.encoder),
		.ctrl       (ctrl),
		.shiftCount (shiftCount)
	);

endmodule

//--- verilog/stage1_defs.svh
`ifndef STAGE1_DEFS_SVH
`define STAGE1_DEFS_SVH

// Word widths
`define INSTR_W     8
`define OPC_W       5
`define FLAG_W      3
`define DATA_W      8
`define CTRL_W      11
`define SHIFT_W     3

`define MISS_LIMIT  11  // Miss cycles before a forced exit

// Opcodes kept from the stage-0 encoding
`define OP_ADD      5'b00000
`define OP_SUB      5'b00001
`define OP_OR       5'b00011
`define OP_AND      5'b00100
`define OP_SHFT     5'b00101
`define OP_LOAD     5'b01010
`define OP_STOR     5'b01011
`define OP_NOP      5'b01111

// Addressing flags
`define FL_DIR      3'd0
`define FL_IND      3'd1
`define FL_IMM      3'd2

// Shift flags
`define FL_LS0      3'd0
`define FL_LS1      3'd1
`define FL_RS0      3'd2
`define FL_RS1      3'd3

////////////////////
// Control word bits
`define CB_MARLOAD  0
`define CB_MEMREAD  1
`define CB_MEMWRITE 2
`define CB_ALUFUNC  3   // Low bit of the 3-bit ALU field
`define CB_OPSEL    6
`define CB_ACCWRITE 7
`define CB_SHIFTEN  8
`define CB_SHIFTDIR 9
`define CB_SHIFTFILL 10

`endif
